// File: afifo.f
hdl/afifo_pkg.sv
hdl/afifo_dpram.sv
hdl/afifo_sync2.sv
hdl/afifo_wptr_full.sv
hdl/afifo_rptr_empty.sv
hdl/afifo_top.sv
tb/afifo_tb.sv

// File: hdl/afifo_dpram.sv
`timescale 1ns/1ps

module afifo_dpram (
    input  logic             wclk,
    input  logic             wen,
    input  afifo_pkg::addr_t waddr,
    input  afifo_pkg::data_t wdata,
    input  logic             rclk,
    input  logic             rrstn,
    input  logic             ren,
    input  afifo_pkg::addr_t raddr,
    output afifo_pkg::data_t rdata
);

    import afifo_pkg::*;

    // Storage array, one word per entry
    data_t mem [DEPTH];

    // Write port in the wclk domain
    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port in the rclk domain
    // Holds the last word read until the next accepted read
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: hdl/afifo_pkg.sv
package afifo_pkg;

    // Word width carried through the FIFO
    localparam int DATA_WIDTH = 8;

    // Storage depth, a power of two
    localparam int DEPTH = 16;

    // RAM address width
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // Address plus one wrap bit, so full and empty differ
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // One FIFO word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // RAM address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Binary or Gray pointer with wrap bit
    typedef logic [PTR_WIDTH-1:0] ptr_t;

endpackage

// File: hdl/afifo_rptr_empty.sv
`timescale 1ns/1ps

module afifo_rptr_empty (
    input  logic             rclk,
    input  logic             rrstn,
    input  logic             rinc,
    input  afifo_pkg::ptr_t  wptr_sync,
    output logic             ren,
    output afifo_pkg::addr_t raddr,
    output afifo_pkg::ptr_t  rptr_gray,
    output logic             rempty
);

    import afifo_pkg::*;

    // Binary read pointer with wrap bit
    ptr_t rbin;
    ptr_t rbin_next;
    ptr_t rgray_next;

    // Accepted read only while a word is stored
    assign ren = rinc && !rempty;

    assign rbin_next  = rbin + ptr_t'(ren);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Registered Gray pointer for the crossing into wclk
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin      <= '0;
            rptr_gray <= '0;
        end else begin
            rbin      <= rbin_next;
            rptr_gray <= rgray_next;
        end
    end

    assign raddr = rbin[ADDR_WIDTH-1:0];

    // Empty when both pointers match, wrap bit included
    // Goes high right after the edge that takes the last word
    assign rempty = (rptr_gray == wptr_sync);

    // Empty must block the pointer on the following edge
    a_rbin_hold_empty: assert property (
        @(posedge rclk) disable iff (!rrstn)
        rempty |=> $stable(rbin)
    ) else $error("read pointer advanced while empty");

    // Only one Gray bit may toggle per step into the wclk domain
    a_rgray_one_bit: assert property (
        @(posedge rclk) disable iff (!rrstn)
        $countones(rptr_gray ^ $past(rptr_gray)) <= 1
    ) else $error("rptr_gray changed more than one bit");

endmodule

// File: hdl/afifo_sync2.sv
`timescale 1ns/1ps

module afifo_sync2 (
    input  logic            clk,
    input  logic            rstn,
    input  afifo_pkg::ptr_t ptr_in,
    output afifo_pkg::ptr_t ptr_out
);

    import afifo_pkg::*;

    // First stage, may go metastable
    ptr_t meta_q;

    // Gray input moves one bit per step, so a late capture
    // resolves to either the old or the new pointer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            meta_q  <= '0;
            ptr_out <= '0;
        end else begin
            meta_q  <= ptr_in;
            ptr_out <= meta_q;
        end
    end

endmodule

// File: hdl/afifo_top.sv
`timescale 1ns/1ps

module afifo_top (
    input  logic             wclk,
    input  logic             wrstn,
    input  logic             winc,
    input  afifo_pkg::data_t wdata,
    output logic             wfull,
    input  logic             rclk,
    input  logic             rrstn,
    input  logic             rinc,
    output afifo_pkg::data_t rdata,
    output logic             rempty
);

    import afifo_pkg::*;

    // RAM control from each side
    logic  wen;
    logic  ren;
    addr_t waddr;
    addr_t raddr;

    // Gray pointers, local and synchronized
    ptr_t wptr_gray;
    ptr_t rptr_gray;
    ptr_t wptr_sync;
    ptr_t rptr_sync;

    afifo_dpram u_dpram (
        .wclk  (wclk),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .rclk  (rclk),
        .rrstn (rrstn),
        .ren   (ren),
        .raddr (raddr),
        .rdata (rdata)
    );

    afifo_wptr_full u_wptr (
        .wclk      (wclk),
        .wrstn     (wrstn),
        .winc      (winc),
        .rptr_sync (rptr_sync),
        .wen       (wen),
        .waddr     (waddr),
        .wptr_gray (wptr_gray),
        .wfull     (wfull)
    );

    afifo_rptr_empty u_rptr (
        .rclk      (rclk),
        .rrstn     (rrstn),
        .rinc      (rinc),
        .wptr_sync (wptr_sync),
        .ren       (ren),
        .raddr     (raddr),
        .rptr_gray (rptr_gray),
        .rempty    (rempty)
    );

    // Write pointer into the read domain
    afifo_sync2 u_sync_w2r (
        .clk     (rclk),
        .rstn    (rrstn),
        .ptr_in  (wptr_gray),
        .ptr_out (wptr_sync)
    );

    // Read pointer into the write domain
    afifo_sync2 u_sync_r2w (
        .clk     (wclk),
        .rstn    (wrstn),
        .ptr_in  (rptr_gray),
        .ptr_out (rptr_sync)
    );

endmodule

// File: hdl/afifo_wptr_full.sv
`timescale 1ns/1ps

module afifo_wptr_full (
    input  logic             wclk,
    input  logic             wrstn,
    input  logic             winc,
    input  afifo_pkg::ptr_t  rptr_sync,
    output logic             wen,
    output afifo_pkg::addr_t waddr,
    output afifo_pkg::ptr_t  wptr_gray,
    output logic             wfull
);

    import afifo_pkg::*;

    // Binary write pointer with wrap bit
    ptr_t wbin;
    ptr_t wbin_next;
    ptr_t wgray_next;

    // Read pointer as it looks when the writer is one lap ahead
    ptr_t rptr_lap;

    // Accepted write only while there is room
    assign wen = winc && !wfull;

    assign wbin_next  = wbin + ptr_t'(wen);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // Gray form registered alongside the binary pointer,
    // so the crossing value never glitches
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin      <= '0;
            wptr_gray <= '0;
        end else begin
            wbin      <= wbin_next;
            wptr_gray <= wgray_next;
        end
    end

    assign waddr = wbin[ADDR_WIDTH-1:0];

    // Full when the Gray pointers differ only in the top two bits
    assign rptr_lap = {~rptr_sync[PTR_WIDTH-1:PTR_WIDTH-2], rptr_sync[PTR_WIDTH-3:0]};
    assign wfull    = (wptr_gray == rptr_lap);

    // Full must block the pointer on the following edge
    a_wbin_hold_full: assert property (
        @(posedge wclk) disable iff (!wrstn)
        wfull |=> $stable(wbin)
    ) else $error("write pointer advanced while full");

    // Only one Gray bit may toggle per step into the rclk domain
    a_wgray_one_bit: assert property (
        @(posedge wclk) disable iff (!wrstn)
        $countones(wptr_gray ^ $past(wptr_gray)) <= 1
    ) else $error("wptr_gray changed more than one bit");

endmodule

// File: tb/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb;

    import afifo_pkg::*;

    // Cycles that any single wait may take
    localparam int TIMEOUT = 200;
    localparam logic [31:0] SEED = 32'h54d8_8c29;

    logic  wclk;
    logic  wrstn;
    logic  winc;
    data_t wdata;
    logic  wfull;
    logic  rclk;
    logic  rrstn;
    logic  rinc;
    data_t rdata;
    logic  rempty;

    // Words accepted by the FIFO and not yet read
    data_t model_q[$];

    // Check due after the next rclk edge
    // 0 none, 1 accepted read, 2 read ignored while empty
    int    rd_pend;
    data_t rd_expect;
    data_t rd_hold;

    logic [31:0] lcg_state;

    afifo_top u_dut (
        .wclk   (wclk),
        .wrstn  (wrstn),
        .winc   (winc),
        .wdata  (wdata),
        .wfull  (wfull),
        .rclk   (rclk),
        .rrstn  (rrstn),
        .rinc   (rinc),
        .rdata  (rdata),
        .rempty (rempty)
    );

    // Periods of 14 ns and 10 ns let the domains drift
    always #7 wclk = ~wclk;
    always #5 rclk = ~rclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    // Next wclk edge plus the input delay
    task automatic wclk_step();
        @(posedge wclk);
        #1;
    endtask

    // wfull is stable here until the next wclk edge
    task automatic write_cycle(input logic en, input data_t d, output logic accepted);
        wclk_step();
        accepted = en && !wfull;
        winc     = en;
        wdata    = d;
        if (accepted) begin
            assert (model_q.size() < DEPTH) else
                report_failure("A write was accepted with every entry already stored");
            model_q.push_back(d);
        end
    endtask

    task automatic write_stop();
        wclk_step();
        winc = 1'b0;
    endtask

    // Next rclk edge and the check left by the previous strobe
    task automatic rclk_step();
        @(posedge rclk);
        #1;
        if (rd_pend == 1) begin
            assert (rdata == rd_expect) else
                report_failure($sformatf("Error: rdata expected %h got %h", rd_expect, rdata));
        end else if (rd_pend == 2) begin
            assert (rdata == rd_hold) else
                report_failure($sformatf("Error: rdata expected %h got %h after ignored rinc",
                                         rd_hold, rdata));
        end
        rd_pend = 0;
    endtask

    task automatic read_cycle(input logic en, output logic accepted);
        rclk_step();
        accepted = en && !rempty;
        rinc     = en;
        if (accepted) begin
            assert (model_q.size() > 0) else
                report_failure("A read was accepted with no word stored");
            rd_expect = model_q.pop_front();
            rd_pend   = 1;
        end else if (en) begin
            rd_hold = rdata;
            rd_pend = 2;
        end
    endtask

    task automatic read_stop();
        rclk_step();
        rinc = 1'b0;
    endtask

    task automatic write_word(input data_t d);
        logic accepted;
        write_cycle(1'b1, d, accepted);
        write_stop();
    endtask

    task automatic read_word(input data_t expected);
        logic accepted;
        int   tries;
        accepted = 1'b0;
        tries    = 0;
        while (!accepted) begin
            if (tries == TIMEOUT) begin
                report_failure("rempty never fell while a read was waiting");
            end
            read_cycle(1'b1, accepted);
            tries++;
        end
        assert (rd_expect == expected) else
            report_failure($sformatf("Error: model head expected %h got %h",
                                     expected, rd_expect));
        read_stop();
    endtask

    task automatic fill();
        logic accepted;
        int   cycles;
        // Let the last read pointer reach the write side
        repeat (3) wclk_step();
        accepted = 1'b1;
        cycles   = 0;
        while (accepted) begin
            if (cycles == TIMEOUT) begin
                report_failure("wfull never rose during a fill");
            end
            lcg_state = lcg_next(lcg_state);
            write_cycle(1'b1, lcg_state[23:16], accepted);
            cycles++;
        end
        write_stop();
        assert (model_q.size() == DEPTH) else
            report_failure($sformatf("Error: wfull rose with %h words stored, expected %h",
                                     model_q.size(), DEPTH));
    endtask

    task automatic drain();
        logic accepted;
        logic done;
        int   cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            if (cycles == TIMEOUT) begin
                report_failure("rempty never rose during a drain");
            end
            read_cycle(1'b1, accepted);
            done = !accepted && (model_q.size() == 0);
            cycles++;
        end
        // Last strobe met rempty high so rdata must hold
        read_stop();
        assert (rempty == 1'b1) else
            report_failure($sformatf("Error: rempty expected %h got %h", 1'b1, rempty));
    endtask

    task automatic idle(input int max_cycles);
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap = lcg_state[31:8] % (max_cycles + 1);
        repeat (gap) wclk_step();
    endtask

    task automatic stream_writes(input int count, input logic [31:0] seed);
        logic [31:0] s;
        logic        accepted;
        int          sent;
        int          stall;
        s     = seed;
        sent  = 0;
        stall = 0;
        while (sent < count) begin
            if (stall == TIMEOUT) begin
                report_failure("wfull never fell while streaming writes");
            end
            s = lcg_next(s);
            write_cycle(s[31:30] != 2'b00, s[23:16], accepted);
            if (accepted) begin
                sent++;
                stall = 0;
            end else begin
                stall++;
            end
        end
        write_stop();
    endtask

    task automatic stream_reads(input int count, input logic [31:0] seed);
        logic [31:0] s;
        logic        accepted;
        int          got;
        int          stall;
        s     = seed;
        got   = 0;
        stall = 0;
        while (got < count) begin
            if (stall == TIMEOUT) begin
                report_failure("rempty never fell while streaming reads");
            end
            s = lcg_next(s);
            read_cycle(s[29:28] != 2'b00, accepted);
            if (accepted) begin
                got++;
                stall = 0;
            end else begin
                stall++;
            end
        end
        read_stop();
    endtask

    // Both sides at once with their own LCG sequences
    task automatic stream(input int count);
        logic [31:0] w_state;
        logic [31:0] r_state;
        w_state   = lcg_next(lcg_state);
        r_state   = lcg_next(w_state ^ 32'h9e37_79b9);
        lcg_state = r_state;
        fork
            stream_writes(count, w_state);
            stream_reads(count, r_state);
        join
    endtask

    task automatic skip_comment(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic read_arg(input int fd, output logic [31:0] value);
        int n;
        value = '0;
        n = $fscanf(fd, " %h", value);
        if (n != 1) begin
            report_failure("A trace command is missing its hex value");
        end
    endtask

    initial begin
        int          fd;
        logic [7:0]  cmd;
        logic [31:0] arg;
        wclk      = 1'b0;
        rclk      = 1'b0;
        wrstn     = 1'b0;
        rrstn     = 1'b0;
        winc      = 1'b0;
        wdata     = '0;
        rinc      = 1'b0;
        rd_pend   = 0;
        rd_expect = '0;
        rd_hold   = '0;
        lcg_state = SEED;
        fork
            begin
                repeat (5) @(posedge wclk);
                #1 wrstn = 1'b1;
            end
            begin
                repeat (5) @(posedge rclk);
                #1 rrstn = 1'b1;
            end
        join
        rclk_step();
        assert (rempty === 1'b1) else
            report_failure($sformatf("Error: rempty expected %h got %h", 1'b1, rempty));
        assert (rdata === '0) else
            report_failure($sformatf("Error: rdata expected %h got %h", 8'h00, rdata));
        wclk_step();
        assert (wfull === 1'b0) else
            report_failure($sformatf("Error: wfull expected %h got %h", 1'b0, wfull));
        fd = $fopen("tb/afifo_trace.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the trace file tb/afifo_trace.txt");
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": skip_comment(fd);
                "W": begin
                    read_arg(fd, arg);
                    write_word(arg[7:0]);
                end
                "R": begin
                    read_arg(fd, arg);
                    read_word(arg[7:0]);
                end
                "F": fill();
                "D": drain();
                "G": begin
                    read_arg(fd, arg);
                    idle(arg);
                end
                "S": begin
                    read_arg(fd, arg);
                    stream(arg);
                end
                default: report_failure($sformatf("Unknown trace command %c", cmd));
            endcase
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb/afifo_trace.txt
# Columns: command, then a hex value. W <data> write, R <data> read and expect,
# F fill until full, D drain until empty, G <n> idle up to n, S <n> stream n words
# Short round trip
W 11
W 22
W 33
R 11
R 22
R 33
D
G 6
# Fill with no reads, then writes while full are dropped
F
W 5a
W a5
D
G 5
# Single words interleaved across the wrap
W 01
W 02
W 03
W 04
R 01
W 05
R 02
R 03
W 06
W 07
R 04
R 05
W 08
R 06
R 07
R 08
D
G 4
# Corner data values
W 00
W ff
W 80
W 7f
W 55
W aa
R 00
R ff
R 80
R 7f
R 55
R aa
D
# Overlapping streams with random gaps
S 40
D
G 7
F
D
G 3
S 64
D
W c3
W 3c
W 96
R c3
W 69
R 3c
R 96
R 69
D
G 8
S 96
D
F
W 0f
D
G 2
W e1
W e2
W e3
W e4
W e5
W e6
W e7
W e8
R e1
R e2
R e3
R e4
R e5
R e6
R e7
R e8
D
S 78
D
G 5
F
D
